//--- Bender.yml
package:
  name: data_feeder

sources:
  - logic/feeder_pkg.sv
  - logic/feeder_regs.sv
  - logic/dram_read_requester.sv
  - logic/line_feeder.sv
  - logic/data_feeder.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/data_feeder_tb.sv

//--- data_feeder.f
+incdir+tests
logic/feeder_pkg.sv
logic/feeder_regs.sv
logic/dram_read_requester.sv
logic/line_feeder.sv
logic/data_feeder.sv
tests/data_feeder_tb.sv

//--- logic/data_feeder.sv
`timescale 1ns/1ps

module data_feeder (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  feeder_pkg::bus_req_t          bus_req_i,
    input  feeder_pkg::accel_rsp_t        accel_rsp_i,
    input  logic                          fifo_addr_full_i,
    input  logic                          dram_rw_full_i,
    input  logic                          fifo_data_empty_i,
    input  logic [feeder_pkg::LINE_W-1:0] dram_read_data_i,  // h and l halves joined
    output feeder_pkg::bus_rsp_t          bus_rsp_o,
    output feeder_pkg::accel_cmd_t        accel_cmd_o,
    output feeder_pkg::dram_req_t         dram_req_o,
    output logic                          fifo_data_rd_en_o
);
    import feeder_pkg::*;

    read_cfg_t         cfg;
    logic              start;
    logic              to_accel;
    logic              data_type;
    logic              sram_clear;
    logic              req_busy;
    logic              feed_busy;
    logic              engines_busy;
    logic [WORD_W-1:0] sw_word;
    accel_cmd_t        direct_cmd;
    accel_cmd_t        stream_cmd;

    assign engines_busy = req_busy || feed_busy;

    feeder_regs feeder_regs_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .bus_req_i      (bus_req_i),
        .accel_rsp_i    (accel_rsp_i),
        .engines_busy_i (engines_busy),
        .sw_word_i      (sw_word),
        .bus_rsp_o      (bus_rsp_o),
        .cfg_o          (cfg),
        .start_o        (start),
        .to_accel_o     (to_accel),
        .data_type_o    (data_type),
        .sram_clear_o   (sram_clear),
        .direct_cmd_o   (direct_cmd)
    );

    dram_read_requester dram_read_requester_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .start_i          (start),
        .cfg_i            (cfg),
        .fifo_addr_full_i (fifo_addr_full_i),
        .dram_rw_full_i   (dram_rw_full_i),
        .dram_req_o       (dram_req_o),
        .busy_o           (req_busy)
    );

    line_feeder line_feeder_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .start_i           (start),
        .to_accel_i        (to_accel),
        .data_type_i       (data_type),
        .sram_clear_i      (sram_clear),
        .cfg_i             (cfg),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_read_data_i  (dram_read_data_i),
        .fifo_data_rd_en_o (fifo_data_rd_en_o),
        .stream_cmd_o      (stream_cmd),
        .sw_word_o         (sw_word),
        .busy_o            (feed_busy)
    );

    // direct commands only come while idle, so the two never overlap
    assign accel_cmd_o = stream_cmd.valid ? stream_cmd : direct_cmd;

endmodule

//--- logic/dram_read_requester.sv
`timescale 1ns/1ps

module dram_read_requester (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  feeder_pkg::read_cfg_t cfg_i,
    input  logic                  fifo_addr_full_i,
    input  logic                  dram_rw_full_i,
    output feeder_pkg::dram_req_t dram_req_o,
    output logic                  busy_o
);
    import feeder_pkg::*;

    typedef enum logic [1:0] {
        IDLE_S,
        WAIT_FIFO_S,
        SEND_S,
        NEXT_ROUND_S
    } state_t;

    state_t             state_q;
    state_t             state_d;
    logic [XLEN-1:0]    addr_q;
    logic [XLEN-1:0]    base_q;     // start of current round
    logic [LEN_W-1:0]   req_cnt_q;  // words requested this round
    logic [ROUND_W-1:0] round_q;
    logic [6:0]         step;
    logic [LEN_W-1:0]   cnt_next;
    logic               last_round;

    assign step       = 7'd64 - {1'b0, addr_q[5:0]};  // bytes to next line
    assign cnt_next   = req_cnt_q + LEN_W'(step[6:1]);
    assign last_round = (round_q + ROUND_W'(1)) >= cfg_i.rounds;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE_S:       if (start_i) state_d = WAIT_FIFO_S;
            WAIT_FIFO_S:  if (!fifo_addr_full_i && !dram_rw_full_i) state_d = SEND_S;
            SEND_S:       state_d = (cnt_next >= cfg_i.len) ? NEXT_ROUND_S : WAIT_FIFO_S;
            NEXT_ROUND_S: state_d = last_round ? IDLE_S : WAIT_FIFO_S;
            default:      state_d = IDLE_S;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE_S;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q    <= '0;
            base_q    <= '0;
            req_cnt_q <= '0;
            round_q   <= '0;
        end else begin
            case (state_q)
                IDLE_S: begin
                    if (start_i) begin
                        addr_q    <= cfg_i.base;
                        base_q    <= cfg_i.base;
                        req_cnt_q <= '0;
                        round_q   <= '0;
                    end
                end
                SEND_S: begin
                    addr_q    <= addr_q + XLEN'(step);
                    req_cnt_q <= cnt_next;
                end
                NEXT_ROUND_S: begin
                    addr_q    <= base_q + cfg_i.offset;
                    base_q    <= base_q + cfg_i.offset;
                    req_cnt_q <= '0;
                    round_q   <= round_q + ROUND_W'(1);
                end
                default: ;
            endcase
        end
    end

    assign dram_req_o = '{valid: (state_q == SEND_S), addr: addr_q, rw: 1'b0};
    assign busy_o     = (state_q != IDLE_S);

endmodule

//--- logic/feeder_pkg.sv
package feeder_pkg;

    // ##################################################################
    // widths
    localparam int XLEN       = 32;
    localparam int WORD_W     = 16;
    localparam int LINE_W     = 512;
    localparam int LINE_WORDS = LINE_W / WORD_W;
    localparam int WIDX_W     = $clog2(LINE_WORDS);
    localparam int LEN_W      = 15;
    localparam int ROUND_W    = 16;
    localparam int CMD_W      = 8;

    // ##################################################################
    // register map
    localparam logic [XLEN-1:0] CMD_ADDR       = 32'hC400_0000;
    localparam logic [XLEN-1:0] PARAM1_ADDR    = 32'hC400_0004;
    localparam logic [XLEN-1:0] PARAM2_ADDR    = 32'hC400_0008;
    localparam logic [XLEN-1:0] RET_ADDR       = 32'hC400_0010;
    localparam logic [XLEN-1:0] BUSY_ADDR      = 32'hC400_0020;
    localparam logic [XLEN-1:0] RD_ADDR_ADDR   = 32'hC400_2024;
    localparam logic [XLEN-1:0] RD_LEN_ADDR    = 32'hC400_2028;
    localparam logic [XLEN-1:0] XFER_ADDR      = 32'hC400_2030; // 1 to accel, 0 peek
    localparam logic [XLEN-1:0] SRAM_OFS_ADDR  = 32'hC400_2034;
    localparam logic [XLEN-1:0] DATA_TYPE_ADDR = 32'hC400_2038; // 0 input, 1 weight
    localparam logic [XLEN-1:0] SW_DATA_ADDR   = 32'hC400_205C;
    localparam logic [XLEN-1:0] RD_OFFSET_ADDR = 32'hC400_2070;
    localparam logic [XLEN-1:0] RD_ROUNDS_ADDR = 32'hC400_2074;

    localparam logic [CMD_W-1:0] CMD_LOAD_INPUT  = 8'd9;
    localparam logic [CMD_W-1:0] CMD_LOAD_WEIGHT = 8'd10;

    // ##################################################################
    // structs
    typedef struct packed {
        logic            strobe;
        logic [XLEN-1:0] addr;
        logic            rw;    // 1 write, 0 read
        logic [XLEN-1:0] data;
    } bus_req_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] data;
    } bus_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [CMD_W-1:0]  cmd;
        logic [WORD_W-1:0] param1;  // data word
        logic [WORD_W-1:0] param2;  // sram index
    } accel_cmd_t;

    typedef struct packed {
        logic              busy;
        logic              ret_valid;
        logic [WORD_W-1:0] ret_data;
    } accel_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;  // byte address
        logic            rw;    // 0 read
    } dram_req_t;

    typedef struct packed {
        logic [XLEN-1:0]    base;
        logic [LEN_W-1:0]   len;     // words per round
        logic [XLEN-1:0]    offset;  // bytes between rounds
        logic [ROUND_W-1:0] rounds;
    } read_cfg_t;

    // halves swapped low/high, pairs top down, even word in the low half of a pair
    function automatic logic [WORD_W-1:0] word_of_line(input logic [LINE_W-1:0] line,
                                                       input logic [WIDX_W-1:0] k);
        int j;
        int lo;
        j  = int'(k) % (LINE_WORDS / 2);
        lo = WORD_W * (LINE_WORDS / 2 - 2 - (j - j % 2) + j % 2);
        if (int'(k) >= LINE_WORDS / 2) begin
            lo = lo + LINE_W / 2;
        end
        return line[lo +: WORD_W];
    endfunction

endpackage

//--- logic/feeder_regs.sv
`timescale 1ns/1ps

module feeder_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  feeder_pkg::bus_req_t          bus_req_i,
    input  feeder_pkg::accel_rsp_t        accel_rsp_i,
    input  logic                          engines_busy_i,
    input  logic [feeder_pkg::WORD_W-1:0] sw_word_i,
    output feeder_pkg::bus_rsp_t          bus_rsp_o,
    output feeder_pkg::read_cfg_t         cfg_o,
    output logic                          start_o,
    output logic                          to_accel_o,
    output logic                          data_type_o,
    output logic                          sram_clear_o,
    output feeder_pkg::accel_cmd_t        direct_cmd_o
);
    import feeder_pkg::*;

    logic              wr_en;
    logic              rd_en;
    logic              cmd_wr;
    logic              strobe_q;  // strobe seen on the last edge
    logic              ready_q;
    logic [XLEN-1:0]   rdata_q;
    logic [WORD_W-1:0] ret_q;   // last accelerator result

    assign wr_en  = bus_req_i.strobe && bus_req_i.rw;
    assign rd_en  = bus_req_i.strobe && !bus_req_i.rw;
    assign cmd_wr = wr_en && (bus_req_i.addr == CMD_ADDR);

    // both engines see the start on the write edge itself
    assign start_o      = wr_en && (bus_req_i.addr == XFER_ADDR);
    assign sram_clear_o = wr_en && (bus_req_i.addr == SRAM_OFS_ADDR);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_o.base   <= '0;
            cfg_o.len    <= '0;
            cfg_o.offset <= '0;
            cfg_o.rounds <= ROUND_W'(1);
            to_accel_o   <= 1'b0;
            data_type_o  <= 1'b0;
        end else if (wr_en) begin
            case (bus_req_i.addr)
                RD_ADDR_ADDR:   cfg_o.base   <= bus_req_i.data;
                RD_LEN_ADDR:    cfg_o.len    <= bus_req_i.data[LEN_W-1:0];
                RD_OFFSET_ADDR: cfg_o.offset <= bus_req_i.data;
                RD_ROUNDS_ADDR: cfg_o.rounds <= bus_req_i.data[ROUND_W-1:0];
                XFER_ADDR:      to_accel_o   <= bus_req_i.data[0];  // mode rides with start
                DATA_TYPE_ADDR: data_type_o  <= bus_req_i.data[0];
                default: ;
            endcase
        end
    end

    // direct command, params stay latched between commands
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            direct_cmd_o.valid <= 1'b0;
        end else begin
            direct_cmd_o.valid <= cmd_wr;
        end
        if (wr_en) begin
            case (bus_req_i.addr)
                CMD_ADDR:    direct_cmd_o.cmd    <= bus_req_i.data[CMD_W-1:0];
                PARAM1_ADDR: direct_cmd_o.param1 <= bus_req_i.data[WORD_W-1:0];
                PARAM2_ADDR: direct_cmd_o.param2 <= bus_req_i.data[WORD_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accel_rsp_i.ret_valid) begin
            ret_q <= accel_rsp_i.ret_data;
        end
    end

    // ##################################################################
    // read-back and ready
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rdata_q <= '0;
        end else if (rd_en) begin
            case (bus_req_i.addr)
                BUSY_ADDR:    rdata_q <= XLEN'(accel_rsp_i.busy || engines_busy_i);
                RET_ADDR:     rdata_q <= XLEN'(ret_q);
                SW_DATA_ADDR: rdata_q <= XLEN'(sw_word_i);
                default:      rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            strobe_q <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            strobe_q <= bus_req_i.strobe;
            ready_q  <= strobe_q;  // one cycle per strobe, one edge late
        end
    end

    assign bus_rsp_o = '{ready: ready_q, data: rdata_q};

endmodule

//--- logic/line_feeder.sv
`timescale 1ns/1ps

module line_feeder (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  logic                          to_accel_i,
    input  logic                          data_type_i,
    input  logic                          sram_clear_i,
    input  feeder_pkg::read_cfg_t         cfg_i,
    input  logic                          fifo_data_empty_i,
    input  logic [feeder_pkg::LINE_W-1:0] dram_read_data_i,
    output logic                          fifo_data_rd_en_o,
    output feeder_pkg::accel_cmd_t        stream_cmd_o,
    output logic [feeder_pkg::WORD_W-1:0] sw_word_o,
    output logic                          busy_o
);
    import feeder_pkg::*;

    typedef enum logic [2:0] {
        IDLE_S,
        WAIT_DATA_S,
        FEED_S,
        POP_S,
        PEEK_S,
        NEXT_ROUND_S
    } state_t;

    state_t             state_q;
    state_t             state_d;
    logic [LINE_W-1:0]  line_q;
    logic [XLEN-1:0]    addr_q;   // running byte address
    logic [XLEN-1:0]    base_q;
    logic [LEN_W-1:0]   sent_q;   // words sent this round
    logic [LEN_W-1:0]   index_q;  // accelerator sram index
    logic [ROUND_W-1:0] round_q;
    logic [WORD_W-1:0]  cur_word;
    logic               line_end;
    logic               round_end;
    logic               last_round;

    assign cur_word   = word_of_line(line_q, addr_q[WIDX_W:1]);
    assign line_end   = (addr_q[5:0] == 6'd62);
    assign round_end  = (sent_q == cfg_i.len - LEN_W'(1));
    assign last_round = (round_q + ROUND_W'(1)) >= cfg_i.rounds;

    // ##################################################################
    // sequencer
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE_S: if (start_i) state_d = WAIT_DATA_S;
            WAIT_DATA_S: begin
                if (!fifo_data_empty_i) begin
                    state_d = to_accel_i ? FEED_S : PEEK_S;
                end
            end
            FEED_S:       if (round_end || line_end) state_d = POP_S;
            POP_S:        state_d = (sent_q == cfg_i.len) ? NEXT_ROUND_S : WAIT_DATA_S;
            PEEK_S:       state_d = IDLE_S;  // single word only
            NEXT_ROUND_S: state_d = last_round ? IDLE_S : WAIT_DATA_S;
            default:      state_d = IDLE_S;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE_S;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q  <= '0;
            base_q  <= '0;
            sent_q  <= '0;
            round_q <= '0;
        end else begin
            case (state_q)
                IDLE_S: begin
                    if (start_i) begin
                        addr_q  <= cfg_i.base;
                        base_q  <= cfg_i.base;
                        sent_q  <= '0;
                        round_q <= '0;
                    end
                end
                FEED_S: begin
                    addr_q <= addr_q + XLEN'(2);
                    sent_q <= sent_q + LEN_W'(1);
                end
                NEXT_ROUND_S: begin
                    addr_q  <= base_q + cfg_i.offset;
                    base_q  <= base_q + cfg_i.offset;
                    sent_q  <= '0;
                    round_q <= round_q + ROUND_W'(1);
                end
                default: ;
            endcase
        end
    end

    // index survives transfers, only SRAM_OFS clears it
    always_ff @(posedge clk_i) begin
        if (rst_i || sram_clear_i) begin
            index_q <= '0;
        end else if (state_q == FEED_S) begin
            index_q <= index_q + LEN_W'(1);
        end
    end

    // ##################################################################
    // line capture and peek
    always_ff @(posedge clk_i) begin
        if (!fifo_data_empty_i) begin
            line_q <= dram_read_data_i;  // follows fifo head
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sw_word_o <= '0;
        end else if (state_q == PEEK_S) begin
            sw_word_o <= cur_word;
        end
    end

    always_comb begin
        stream_cmd_o.valid  = (state_q == FEED_S);
        stream_cmd_o.cmd    = data_type_i ? CMD_LOAD_WEIGHT : CMD_LOAD_INPUT;
        stream_cmd_o.param1 = cur_word;
        stream_cmd_o.param2 = WORD_W'(index_q);
    end

    assign fifo_data_rd_en_o = (state_q == POP_S) || (state_q == PEEK_S);
    assign busy_o            = (state_q != IDLE_S);

endmodule

//--- tests/data_feeder_tasks.svh
// ######################################################################
// stimulus helpers

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// word k of a line: halves low/high, pairs from the top of a half, even word low
function automatic logic [WORD_W-1:0] expect_word(input logic [LINE_W-1:0] line,
                                                  input logic [4:0] k);
    int half;
    int pair;
    int lo;
    half = int'(k) / 16;
    pair = (int'(k) % 16) / 2;
    lo   = 256 * half + 224 - 32 * pair + 16 * (int'(k) % 2);
    return line[lo +: WORD_W];
endfunction

// ######################################################################
// compare tasks
task automatic check_accel_cmd(input accel_cmd_t got, input accel_cmd_t exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_dram_req(input dram_req_t got, input dram_req_t exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_bus_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

// ######################################################################
// bus access, one strobe then wait for the ready pulse
task automatic bus_access(input logic rw, input logic [XLEN-1:0] addr,
                          input logic [XLEN-1:0] data, output bus_rsp_t rsp);
    int cyc;
    @(posedge clk_i);
    #1;
    bus_req_i = '{strobe: 1'b1, addr: addr, rw: rw, data: data};
    @(posedge clk_i);
    #1;
    bus_req_i.strobe = 1'b0;
    cyc = 0;
    @(negedge clk_i);
    while (!bus_rsp_o.ready && cyc < 20) begin
        @(negedge clk_i);
        cyc++;
    end
    rsp = bus_rsp_o;
    if (!bus_rsp_o.ready) begin
        timeouts++;
        $display("timeout: no bus ready for address %h", addr);
    end else begin
        if (cyc != 1) begin
            errors++;
            $display("FAILED at %0t: bus ready at the wrong cycle for address %h", $time, addr);
        end
        @(negedge clk_i);
        if (bus_rsp_o.ready) begin
            errors++;
            $display("FAILED at %0t: bus ready held longer than one cycle", $time);
        end
    end
endtask

task automatic bus_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    bus_rsp_t rsp;
    bus_access(1'b1, addr, data, rsp);
endtask

task automatic bus_read(input logic [XLEN-1:0] addr, output bus_rsp_t rsp);
    bus_access(1'b0, addr, '0, rsp);
endtask

// poll BUSY until both engines and the accelerator are done
task automatic wait_idle(input string what);
    bus_rsp_t rsp;
    int tries;
    tries = 0;
    bus_read(BUSY_ADDR, rsp);
    while (rsp.data != 0 && tries < 200) begin
        bus_read(BUSY_ADDR, rsp);
        tries++;
    end
    if (rsp.data != 0) begin
        timeouts++;
        $display("timeout: feeder still busy during %s", what);
    end
endtask

//--- tests/data_feeder_tb.sv
`timescale 1ns/1ps

module data_feeder_tb;
    import feeder_pkg::*;

    logic              clk_i;
    logic              rst_i;
    bus_req_t          bus_req_i;
    accel_rsp_t        accel_rsp_i;
    logic              fifo_addr_full_i;
    logic              dram_rw_full_i;
    logic              fifo_data_empty_i;
    logic [LINE_W-1:0] dram_read_data_i;
    bus_rsp_t          bus_rsp_o;
    accel_cmd_t        accel_cmd_o;
    dram_req_t         dram_req_o;
    logic              fifo_data_rd_en_o;

    int                errors   = 0;
    int                timeouts = 0;
    int                pop_count;
    logic              hold_empty;   // forces the data FIFO to look empty
    logic              pop_pending;
    logic [15:0]       lfsr_q;
    logic [LINE_W-1:0] new_line;
    logic [LINE_W-1:0] fifo_q[$];
    logic [LINE_W-1:0] line_log[$];  // every returned line, in order
    accel_cmd_t        cmd_q[$];
    dram_req_t         req_q[$];

    `include "data_feeder_tasks.svh"

    data_feeder data_feeder_inst (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .bus_req_i         (bus_req_i),
        .accel_rsp_i       (accel_rsp_i),
        .fifo_addr_full_i  (fifo_addr_full_i),
        .dram_rw_full_i    (dram_rw_full_i),
        .fifo_data_empty_i (fifo_data_empty_i),
        .dram_read_data_i  (dram_read_data_i),
        .bus_rsp_o         (bus_rsp_o),
        .accel_cmd_o       (accel_cmd_o),
        .dram_req_o        (dram_req_o),
        .fifo_data_rd_en_o (fifo_data_rd_en_o)
    );

    always #4 clk_i = ~clk_i;

    // ##################################################################
    // monitor and DRAM model, sampled mid-cycle
    always @(negedge clk_i) begin
        if (accel_cmd_o.valid) cmd_q.push_back(accel_cmd_o);
        if (dram_req_o.valid) begin
            req_q.push_back(dram_req_o);
            for (int b = 0; b < LINE_W; b++) begin
                lfsr_q      = lfsr_step(lfsr_q);
                new_line[b] = lfsr_q[0];
            end
            fifo_q.push_back(new_line);
            line_log.push_back(new_line);
        end
        if (fifo_data_rd_en_o) begin
            pop_count++;
            pop_pending = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        #1;
        if (pop_pending) begin
            if (fifo_q.size() == 0) begin
                errors++;
                $display("pop from an empty data FIFO at %0t", $time);
            end else begin
                fifo_q.delete(0);
            end
            pop_pending = 1'b0;
        end
        fifo_data_empty_i = hold_empty || (fifo_q.size() == 0);
        dram_read_data_i  = (fifo_q.size() != 0) ? fifo_q[0] : '0;
    end

    // ##################################################################
    // test helpers
    task automatic clear_logs();
        @(posedge clk_i);
        #2;
        if (fifo_q.size() != 0) begin
            errors++;
            $display("data FIFO not drained before a new test");
        end
        cmd_q.delete();
        req_q.delete();
        line_log.delete();
        pop_count = 0;
    endtask

    task automatic configure(input logic [XLEN-1:0] base, input int len, input int rounds,
                             input logic [XLEN-1:0] ofs);
        bus_write(RD_ADDR_ADDR, base);
        bus_write(RD_LEN_ADDR, len);
        bus_write(RD_ROUNDS_ADDR, rounds);
        bus_write(RD_OFFSET_ADDR, ofs);
    endtask

    task automatic check_stream(input logic [XLEN-1:0] base, input int len, input int rounds,
                                input logic [XLEN-1:0] ofs, input logic [CMD_W-1:0] code);
        logic [XLEN-1:0] a;
        accel_cmd_t      exp;
        int              li;
        int              n;
        li = 0;
        n  = 0;
        if (cmd_q.size() != len * rounds) begin
            errors++;
            $display("FAILED at %0t: %0d commands, expected %0d", $time, cmd_q.size(),
                     len * rounds);
        end
        for (int r = 0; r < rounds; r++) begin
            a = base + r * ofs;
            for (int w = 0; w < len; w++) begin
                exp = '{valid: 1'b1, cmd: code, param1: expect_word(line_log[li], a[5:1]),
                        param2: WORD_W'(n)};
                if (n < cmd_q.size()) check_accel_cmd(cmd_q[n], exp, "streamed command");
                if (a[5:0] == 6'd62 || w == len - 1) li++;  // line consumed
                a = a + 2;
                n++;
            end
        end
        if (pop_count != li) begin
            errors++;
            $display("FAILED at %0t: %0d pops, expected %0d", $time, pop_count, li);
        end
    endtask

    // ##################################################################
    // directed tests
    task automatic test_reset_and_bus();
        bus_rsp_t rsp;
        @(negedge clk_i);
        if (accel_cmd_o.valid || dram_req_o.valid || fifo_data_rd_en_o || bus_rsp_o.ready) begin
            errors++;
            $display("FAILED at %0t: an output valid is high after reset", $time);
        end
        bus_write(DATA_TYPE_ADDR, 0);
        bus_read(BUSY_ADDR, rsp);
        check_bus_rsp(rsp, bus_rsp_t'{ready: 1'b1, data: 32'd0}, "busy after reset");
    endtask

    task automatic test_direct_cmd();
        bus_rsp_t rsp;
        int       cyc;
        clear_logs();
        bus_write(PARAM1_ADDR, 32'h1234);
        bus_write(PARAM2_ADDR, 32'h0056);
        bus_write(CMD_ADDR, CMD_LOAD_INPUT);
        cyc = 0;
        while (cmd_q.size() == 0 && cyc < 10) begin
            @(negedge clk_i);
            cyc++;
        end
        repeat (5) @(negedge clk_i);  // no repeat of the command
        if (cmd_q.size() != 1) begin
            errors++;
            $display("FAILED at %0t: %0d direct commands seen, expected 1", $time, cmd_q.size());
        end else begin
            check_accel_cmd(cmd_q[0], accel_cmd_t'{valid: 1'b1, cmd: CMD_LOAD_INPUT,
                            param1: 16'h1234, param2: 16'h0056}, "direct command");
        end
        @(posedge clk_i);
        #1;
        accel_rsp_i = '{busy: 1'b0, ret_valid: 1'b1, ret_data: 16'hBEEF};
        @(posedge clk_i);
        #1;
        accel_rsp_i.ret_valid = 1'b0;
        bus_read(RET_ADDR, rsp);
        check_bus_rsp(rsp, bus_rsp_t'{ready: 1'b1, data: 32'h0000_BEEF}, "result read");
    endtask

    task automatic test_request_stream();
        logic [XLEN-1:0] a;
        int              cnt;
        dram_req_t       exp_q[$];
        clear_logs();
        bus_write(DATA_TYPE_ADDR, 1);
        configure(32'h1000_0012, 40, 2, 32'h100);
        @(posedge clk_i);
        #1;
        fifo_addr_full_i = 1'b1;
        bus_write(XFER_ADDR, 1);
        repeat (20) @(negedge clk_i);
        if (req_q.size() != 0) begin
            errors++;
            $display("FAILED at %0t: request issued while the address FIFO is full", $time);
        end
        @(posedge clk_i);
        #1;
        fifo_addr_full_i = 1'b0;
        wait_idle("request stream");
        for (int r = 0; r < 2; r++) begin
            a   = 32'h1000_0012 + r * 32'h100;
            cnt = 0;
            while (cnt < 40) begin
                exp_q.push_back('{valid: 1'b1, addr: a, rw: 1'b0});
                cnt = cnt + (64 - int'(a[5:0])) / 2;
                a   = a + 64 - a[5:0];  // next line boundary
            end
        end
        if (req_q.size() != exp_q.size()) begin
            errors++;
            $display("FAILED at %0t: %0d requests, expected %0d", $time, req_q.size(),
                     exp_q.size());
        end
        foreach (exp_q[i]) begin
            if (i < req_q.size()) check_dram_req(req_q[i], exp_q[i], "dram request");
        end
    endtask

    task automatic test_feeding();
        clear_logs();
        bus_write(DATA_TYPE_ADDR, 1);
        bus_write(SRAM_OFS_ADDR, 0);
        configure(32'h2000_0006, 40, 2, 32'h80);
        bus_write(XFER_ADDR, 1);
        wait_idle("weight feed");
        check_stream(32'h2000_0006, 40, 2, 32'h80, CMD_LOAD_WEIGHT);
    endtask

    task automatic test_peek();
        bus_rsp_t rsp;
        clear_logs();
        configure(32'h3000_002A, 1, 1, 32'h0);
        bus_write(XFER_ADDR, 0);
        wait_idle("peek");
        if (pop_count != 1 || cmd_q.size() != 0) begin
            errors++;
            $display("FAILED at %0t: peek made %0d pops and %0d commands", $time, pop_count,
                     cmd_q.size());
        end
        bus_read(SW_DATA_ADDR, rsp);
        check_bus_rsp(rsp, bus_rsp_t'{ready: 1'b1, data: XLEN'(expect_word(line_log[0], 5'd21))},
                      "peeked word");
        bus_read(BUSY_ADDR, rsp);
        check_bus_rsp(rsp, bus_rsp_t'{ready: 1'b1, data: 32'd0}, "busy after peek");
    endtask

    task automatic test_empty_stall();
        bus_rsp_t rsp;
        clear_logs();
        bus_write(DATA_TYPE_ADDR, 0);
        bus_write(SRAM_OFS_ADDR, 0);
        configure(32'h4000_0004, 8, 1, 32'h0);
        @(posedge clk_i);
        #1;
        hold_empty = 1'b1;
        bus_write(XFER_ADDR, 1);
        repeat (20) @(negedge clk_i);
        if (cmd_q.size() != 0) begin
            errors++;
            $display("FAILED at %0t: commands streamed from an empty FIFO", $time);
        end
        bus_read(BUSY_ADDR, rsp);
        check_bus_rsp(rsp, bus_rsp_t'{ready: 1'b1, data: 32'd1}, "busy during stall");
        @(posedge clk_i);
        #1;
        hold_empty = 1'b0;
        wait_idle("stall release");
        check_stream(32'h4000_0004, 8, 1, 32'h0, CMD_LOAD_INPUT);
    endtask

    initial begin
        clk_i             = 1'b0;
        rst_i             = 1'b1;
        bus_req_i         = '0;
        accel_rsp_i       = '0;
        fifo_addr_full_i  = 1'b0;
        dram_rw_full_i    = 1'b0;
        fifo_data_empty_i = 1'b1;
        dram_read_data_i  = '0;
        hold_empty        = 1'b0;
        pop_pending       = 1'b0;
        pop_count         = 0;
        lfsr_q            = 16'd25596;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        test_reset_and_bus();
        test_direct_cmd();
        test_request_stream();
        test_feeding();
        test_peek();
        test_empty_stall();

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
